/* disk_input_top.f */
+incdir+rtl
rtl/disk_pkg.sv
rtl/input_pkg.sv
rtl/sector_buffer.sv
rtl/disk_request_ctrl.sv
rtl/mount_tracker.sv
rtl/pointer_joystick.sv
rtl/disk_input_top.sv
testbench/tb_disk_input_top.sv

/* rtl/disk_input_settings.svh */
// Build-time sizes for the disk-image bridge and the pointer-to-joystick logic.
// Included by the packages and by every module that sizes a port from these values.
`ifndef DISK_INPUT_SETTINGS_SVH
`define DISK_INPUT_SETTINGS_SVH

`default_nettype none

// ============================================================
// Disk bridge
// ============================================================

// Sector buffer address width, 512 bytes
`define DI_BUF_AW 9

// One read and one write request bit per drive
`define DI_DRIVES 8

// ============================================================
// Mouse emulation
// ============================================================

// Largest delta taken from a single packet
`define DI_MOUSE_STEP 10

// Saturation limits of an analog axis
`define DI_AXIS_MAX 127
`define DI_AXIS_MIN (-128)

`default_nettype wire

`endif

/* rtl/disk_input_top.sv */
// Disk-image bridge and pointer-to-joystick emulation for the soft controller.
// Connects the request logic, the sector buffer, the mount tracker and the mouse path.
`include "disk_input_settings.svh"

`default_nettype none

module disk_input_top (
	input  wire logic                   clk_sys,
	input  wire logic                   areset,

	input  wire disk_pkg::host_ctrl_t   host_ctrl_i,
	input  wire logic [31:0]            host_data_i,
	input  wire logic                   data_wr_i,
	input  wire logic                   data_rd_i,
	input  wire logic                   io_wr_i,
	output logic      [31:0]            host_rdata_o,
	output disk_pkg::disk_status_t      host_status_o,

	output disk_pkg::sd_req_t           sd_req_o,
	input  wire logic [`DI_DRIVES-1:0]  sd_ack_i,
	input  wire logic [`DI_BUF_AW-1:0]  sd_buff_addr_i,
	input  wire logic [7:0]             sd_buff_dout_i,
	input  wire logic                   sd_buff_wr_i,
	output logic      [7:0]             sd_buff_din_o,

	input  wire logic [`DI_DRIVES-1:0]  img_mounted_i,
	input  wire logic                   img_readonly_i,
	input  wire logic [31:0]            img_size_i,
	input  wire logic [1:0]             img_type_i,

	input  wire input_pkg::mouse_pkt_t  mouse_i,
	input  wire logic [13:0]            joy0_i,
	input  wire logic [13:0]            joy1_i,
	input  wire input_pkg::analog_t     joya0_i,
	input  wire input_pkg::analog_t     joya1_i,
	input  wire logic                   y_invert_i,
	input  wire logic                   swap_i,
	input  wire logic                   cpu_halt_i,
	output input_pkg::joy_route_t       joy1_o,
	output input_pkg::joy_route_t       joy2_o
);

	logic [`DI_BUF_AW-1:0] buf_addr;
	logic [7:0]            buf_data;
	logic                  buf_wr;
	logic [7:0]            buf_q;
	logic                  io_done;
	logic [2:0]            fileno;
	logic [1:0]            filetype;
	logic                  readonly;
	logic                  mounted;
	logic [31:0]           filesize;

	disk_request_ctrl u_disk_request_ctrl (
		.clk_sys      (clk_sys),
		.areset       (areset),
		.host_ctrl_i  (host_ctrl_i),
		.host_data_i  (host_data_i),
		.data_wr_i    (data_wr_i),
		.data_rd_i    (data_rd_i),
		.io_wr_i      (io_wr_i),
		.buf_q_i      (buf_q),
		.filesize_i   (filesize),
		.sd_ack_i     (sd_ack_i),
		.buf_addr_o   (buf_addr),
		.buf_data_o   (buf_data),
		.buf_wr_o     (buf_wr),
		.sd_req_o     (sd_req_o),
		.io_done_o    (io_done),
		.host_rdata_o (host_rdata_o)
	);

	// Port A for the SD service, port B for the controller
	sector_buffer #(
		.ADDR_W (`DI_BUF_AW),
		.DATA_W (8)
	) u_sector_buffer (
		.clk_sys  (clk_sys),
		.a_addr_i (sd_buff_addr_i),
		.a_data_i (sd_buff_dout_i),
		.a_wr_i   (sd_buff_wr_i),
		.a_q_o    (sd_buff_din_o),
		.b_addr_i (buf_addr),
		.b_data_i (buf_data),
		.b_wr_i   (buf_wr),
		.b_q_o    (buf_q)
	);

	mount_tracker u_mount_tracker (
		.clk_sys        (clk_sys),
		.areset         (areset),
		.img_mounted_i  (img_mounted_i),
		.img_readonly_i (img_readonly_i),
		.img_size_i     (img_size_i),
		.img_type_i     (img_type_i),
		.fileno_o       (fileno),
		.filetype_o     (filetype),
		.readonly_o     (readonly),
		.mounted_o      (mounted),
		.filesize_o     (filesize)
	);

	pointer_joystick u_pointer_joystick (
		.clk_sys    (clk_sys),
		.areset     (areset),
		.mouse_i    (mouse_i),
		.joy0_i     (joy0_i),
		.joy1_i     (joy1_i),
		.joya0_i    (joya0_i),
		.joya1_i    (joya1_i),
		.y_invert_i (y_invert_i),
		.swap_i     (swap_i),
		.cpu_halt_i (cpu_halt_i),
		.joy1_o     (joy1_o),
		.joy2_o     (joy2_o)
	);

	// Status byte polled by the controller
	assign host_status_o.io_done  = io_done;
	assign host_status_o.mounted  = mounted;
	assign host_status_o.fileno   = fileno;
	assign host_status_o.filetype = filetype;
	assign host_status_o.readonly = readonly;

endmodule

`default_nettype wire

/* rtl/disk_pkg.sv */
// Types shared by the controller side and the SD side of the disk-image bridge.
// Ports use scoped names, module bodies import the package.
`include "disk_input_settings.svh"

`default_nettype none

package disk_pkg;

	// Control word written by the soft controller
	typedef struct packed {
		logic       lba_sel;
		logic       block_rd;
		logic       block_wr;
		logic [2:0] drv_num;
	} host_ctrl_t;

	// Status byte read back by the controller, io_done sits in bit 0
	typedef struct packed {
		logic       readonly;
		logic [1:0] filetype;
		logic [2:0] fileno;
		logic       mounted;
		logic       io_done;
	} disk_status_t;

	// Request bundle towards the host SD service
	typedef struct packed {
		logic [`DI_DRIVES-1:0] rd;
		logic [`DI_DRIVES-1:0] wr;
		logic [31:0]           lba;
	} sd_req_t;

endpackage

`default_nettype wire

/* rtl/disk_request_ctrl.sv */
// Turns the controller's strobe levels into buffer accesses, LBA loads and
// per-drive SD requests, and tracks completion through the acknowledge.
`include "disk_input_settings.svh"

`default_nettype none

module disk_request_ctrl (
	input  wire logic                   clk_sys,
	input  wire logic                   areset,

	input  wire disk_pkg::host_ctrl_t   host_ctrl_i,
	input  wire logic [31:0]            host_data_i,
	input  wire logic                   data_wr_i,
	input  wire logic                   data_rd_i,
	input  wire logic                   io_wr_i,

	input  wire logic [7:0]             buf_q_i,
	input  wire logic [31:0]            filesize_i,
	input  wire logic [`DI_DRIVES-1:0]  sd_ack_i,

	output logic      [`DI_BUF_AW-1:0]  buf_addr_o,
	output logic      [7:0]             buf_data_o,
	output logic                        buf_wr_o,

	output disk_pkg::sd_req_t           sd_req_o,
	output logic                        io_done_o,
	output logic      [31:0]            host_rdata_o
);

	import disk_pkg::*;

	// Previous control word, for the block request edges
	host_ctrl_t            ctrl_d;

	logic                  data_wr_d1;
	logic                  data_wr_d2;
	logic                  data_rd_d;
	logic                  ack_d;
	logic                  ack_any;
	logic                  wr_rise;

	logic [`DI_BUF_AW-1:0] addr_q;
	logic [7:0]            wdata_q;
	logic                  wr_q;
	logic [`DI_DRIVES-1:0] rd_req_q;
	logic [`DI_DRIVES-1:0] wr_req_q;
	logic [31:0]           lba_q;
	logic                  io_done_q;

	assign ack_any = |sd_ack_i;

	// Data write strobe acts on the delayed copy, two edges after the rise
	assign wr_rise = data_wr_d1 & ~data_wr_d2;

	// ============================================================
	// Strobe edges, address counter and requests
	// ============================================================
	always_ff @(posedge clk_sys) begin
		if (areset) begin
			ctrl_d     <= '0;
			data_wr_d1 <= 1'b0;
			data_wr_d2 <= 1'b0;
			data_rd_d  <= 1'b0;
			ack_d      <= 1'b0;
			addr_q     <= '0;
			wr_q       <= 1'b0;
			rd_req_q   <= '0;
			wr_req_q   <= '0;
			io_done_q  <= 1'b0;
		end else begin
			ctrl_d     <= host_ctrl_i;
			data_wr_d1 <= data_wr_i;
			data_wr_d2 <= data_wr_d1;
			data_rd_d  <= data_rd_i;
			ack_d      <= ack_any;

			// Buffer write pulse, address moves on once the byte is stored
			wr_q <= wr_rise & ~host_ctrl_i.lba_sel;
			if (wr_q) begin
				addr_q <= addr_q + 1'b1;
			end
			if (data_rd_d & ~data_rd_i) begin
				addr_q <= addr_q + 1'b1;
			end
			if (io_wr_i) begin
				addr_q <= '0;
			end

			if (host_ctrl_i.block_rd & ~ctrl_d.block_rd) begin
				rd_req_q[host_ctrl_i.drv_num] <= 1'b1;
				io_done_q                     <= 1'b0;
			end
			if (host_ctrl_i.block_wr & ~ctrl_d.block_wr) begin
				wr_req_q[host_ctrl_i.drv_num] <= 1'b1;
				io_done_q                     <= 1'b0;
			end

			// Any acknowledge drops every pending request
			if (ack_any) begin
				rd_req_q <= '0;
				wr_req_q <= '0;
			end
			if (ack_d & ~ack_any) begin
				io_done_q <= 1'b1;
			end
		end
	end

	// LBA and write byte are plain payload
	always_ff @(posedge clk_sys) begin
		if (wr_rise) begin
			if (host_ctrl_i.lba_sel) begin
				lba_q <= host_data_i;
			end else begin
				wdata_q <= host_data_i[7:0];
			end
		end
	end

	assign buf_addr_o = addr_q;
	assign buf_data_o = wdata_q;
	assign buf_wr_o   = wr_q;
	assign io_done_o  = io_done_q;
	assign sd_req_o   = '{rd: rd_req_q, wr: wr_req_q, lba: lba_q};

	// File size while the LBA is selected, else the buffer byte
	assign host_rdata_o = host_ctrl_i.lba_sel ? filesize_i : 32'(buf_q_i);

endmodule

`default_nettype wire

/* rtl/input_pkg.sv */
// Types for the mouse packet and the joystick outputs.
// Used by the pointer-to-joystick block and the top level.
`default_nettype none

package input_pkg;

	// PS/2 style mouse packet, stb toggles once per packet
	typedef struct packed {
		logic              stb;
		logic signed [8:0] dy;
		logic signed [8:0] dx;
		logic [1:0]        btn;
		logic [3:0]        pad;
	} mouse_pkt_t;

	// One analog stick, two signed axes
	typedef struct packed {
		logic signed [7:0] y;
		logic signed [7:0] x;
	} analog_t;

	// Joystick as seen by the machine
	typedef struct packed {
		logic [13:0] buttons;
		analog_t     axes;
	} joy_route_t;

endpackage

`default_nettype wire

/* rtl/mount_tracker.sv */
// Records which drive image was mounted last, with its type, size and
// write protection, and flips a toggle the controller polls for changes.
`include "disk_input_settings.svh"

`default_nettype none

module mount_tracker (
	input  wire logic                  clk_sys,
	input  wire logic                  areset,

	input  wire logic [`DI_DRIVES-1:0] img_mounted_i,
	input  wire logic                  img_readonly_i,
	input  wire logic [31:0]           img_size_i,
	input  wire logic [1:0]            img_type_i,

	output logic      [2:0]            fileno_o,
	output logic      [1:0]            filetype_o,
	output logic                       readonly_o,
	output logic                       mounted_o,
	output logic      [31:0]           filesize_o
);

	logic       mount_any;
	logic       mount_d;
	logic       mount_evt;
	logic [2:0] fileno_n;

	assign mount_any = |img_mounted_i;
	assign mount_evt = mount_any & ~mount_d;

	// Highest set bit wins
	always_comb begin
		fileno_n = '0;
		for (int i = 0; i < `DI_DRIVES; i++) begin
			if (img_mounted_i[i]) begin
				fileno_n = 3'(i);
			end
		end
	end

	always_ff @(posedge clk_sys) begin
		if (areset) begin
			mount_d   <= 1'b0;
			mounted_o <= 1'b0;
		end else begin
			mount_d <= mount_any;
			if (mount_evt) begin
				mounted_o <= ~mounted_o;
			end
		end
	end

	// Drives 4 and 5 are always write protected
	always_ff @(posedge clk_sys) begin
		if (mount_evt) begin
			fileno_o   <= fileno_n;
			filetype_o <= img_type_i;
			readonly_o <= img_readonly_i | img_mounted_i[4] | img_mounted_i[5];
			filesize_o <= img_size_i;
		end
	end

endmodule

`default_nettype wire

/* rtl/pointer_joystick.sv */
// Mouse to analog stick emulation for the first joystick, plus the joystick swap.
// Real analog input or a halted CPU hands the stick back to the gamepad.
`include "disk_input_settings.svh"

`default_nettype none

module pointer_joystick (
	input  wire logic                   clk_sys,
	input  wire logic                   areset,

	input  wire input_pkg::mouse_pkt_t  mouse_i,
	input  wire logic [13:0]            joy0_i,
	input  wire logic [13:0]            joy1_i,
	input  wire input_pkg::analog_t     joya0_i,
	input  wire input_pkg::analog_t     joya1_i,

	input  wire logic                   y_invert_i,
	input  wire logic                   swap_i,
	input  wire logic                   cpu_halt_i,

	output input_pkg::joy_route_t       joy1_o,
	output input_pkg::joy_route_t       joy2_o
);

	import input_pkg::*;

	// Per-packet delta limit
	function automatic logic signed [9:0] step_limit(input logic signed [8:0] d);
		if (d > `DI_MOUSE_STEP) begin
			return 10'(`DI_MOUSE_STEP);
		end
		if (d < -(`DI_MOUSE_STEP)) begin
			return -10'(`DI_MOUSE_STEP);
		end
		return {d[8], d};
	endfunction

	function automatic logic [7:0] sat_axis(input logic signed [9:0] v);
		if (v > `DI_AXIS_MAX) begin
			return 8'(`DI_AXIS_MAX);
		end
		if (v < `DI_AXIS_MIN) begin
			return 8'(`DI_AXIS_MIN);
		end
		return v[7:0];
	endfunction

	analog_t           pos_q;
	analog_t           axes0;
	logic              emu_q;
	logic              stb_d;
	logic              analog_active;
	logic [13:0]       buttons0;
	logic signed [9:0] next_x;
	logic signed [9:0] next_y;

	assign analog_active = (joya0_i != '0) | cpu_halt_i;

	assign next_x = 10'($signed(pos_q.x)) + step_limit(mouse_i.dx);
	assign next_y = y_invert_i ? 10'($signed(pos_q.y)) - step_limit(mouse_i.dy)
	                           : 10'($signed(pos_q.y)) + step_limit(mouse_i.dy);

	// ============================================================
	// Position accumulator
	// ============================================================
	always_ff @(posedge clk_sys) begin
		if (areset) begin
			stb_d <= mouse_i.stb;
			emu_q <= 1'b0;
			pos_q <= '0;
		end else begin
			stb_d <= mouse_i.stb;
			if (stb_d != mouse_i.stb) begin
				emu_q   <= 1'b1;
				pos_q.x <= sat_axis(next_x);
				pos_q.y <= sat_axis(next_y);
			end
			// Analog stick or halt takes over, even against a new packet
			if (analog_active) begin
				emu_q <= 1'b0;
				pos_q <= '0;
			end
		end
	end

	// ============================================================
	// Joystick routing
	// ============================================================
	assign axes0    = emu_q ? pos_q : joya0_i;
	assign buttons0 = {joy0_i[13:9], emu_q ? mouse_i.btn : joy0_i[8:7], joy0_i[6:0]};

	always_comb begin
		if (swap_i) begin
			joy1_o = '{buttons: joy1_i, axes: joya1_i};
			joy2_o = '{buttons: buttons0, axes: axes0};
		end else begin
			joy1_o = '{buttons: buttons0, axes: axes0};
			joy2_o = '{buttons: joy1_i, axes: joya1_i};
		end
	end

endmodule

`default_nettype wire

/* rtl/sector_buffer.sv */
// True dual-port byte RAM holding one disk sector.
// Port A belongs to the SD service, port B to the controller.
`default_nettype none

module sector_buffer #(
	parameter int ADDR_W = 9,
	parameter int DATA_W = 8
) (
	input  wire logic              clk_sys,

	input  wire logic [ADDR_W-1:0] a_addr_i,
	input  wire logic [DATA_W-1:0] a_data_i,
	input  wire logic              a_wr_i,
	output logic      [DATA_W-1:0] a_q_o,

	input  wire logic [ADDR_W-1:0] b_addr_i,
	input  wire logic [DATA_W-1:0] b_data_i,
	input  wire logic              b_wr_i,
	output logic      [DATA_W-1:0] b_q_o
);

	logic [DATA_W-1:0] mem [2**ADDR_W];

	// Both ports read the old contents on a same-cycle write
	always_ff @(posedge clk_sys) begin
		if (a_wr_i) begin
			mem[a_addr_i] <= a_data_i;
		end
		if (b_wr_i) begin
			mem[b_addr_i] <= b_data_i;
		end
		a_q_o <= mem[a_addr_i];
		b_q_o <= mem[b_addr_i];
	end

endmodule

`default_nettype wire

/* run.sh */
#!/bin/sh
# Build the testbench with Verilator, run it and look for the pass message.

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
	--top-module tb_disk_input_top -f disk_input_top.f -Mdir obj_dir
if [ $? -ne 0 ]; then
	echo "Verilator build failed"
	exit 1
fi

output=$(./obj_dir/Vtb_disk_input_top)
status=$?
printf '%s\n' "$output"
if [ $status -ne 0 ]; then
	echo "Simulation exited with status $status"
	exit 1
fi

if printf '%s\n' "$output" | grep -qF '*** TEST PASSED ***'; then
	exit 0
else
	echo "Pass message not found in simulation output"
	exit 1
fi

/* testbench/tb_disk_input_top.sv */
// Self-checking testbench for the disk-image bridge and the pointer-to-joystick path.
// Builds a table of operations with expected values and runs it row by row.
`include "disk_input_settings.svh"

`default_nettype none

module tb_disk_input_top;

	timeunit 1ns;
	timeprecision 100ps;

	import disk_pkg::*;
	import input_pkg::*;

	localparam logic [13:0] JOY0_PATTERN = 14'h2a5b;

	typedef enum logic [3:0] {
		OP_LBA, OP_CLR, OP_WR, OP_RD, OP_SDRD, OP_BLOCK, OP_ACK,
		OP_MOUNT, OP_FSIZE, OP_MOUSE, OP_YINV, OP_ANALOG, OP_SWAP, OP_JOY2
	} op_e;

	// One table row, want is compared when chk is set
	typedef struct packed {
		op_e         op;
		logic        chk;
		logic [31:0] arg;
		logic [31:0] aux;
		logic [31:0] want;
	} row_t;

	typedef enum logic [1:0] {STB_DATA_WR, STB_DATA_RD, STB_IO_WR} strobe_e;

	logic         clk_sys = 1'b0;
	logic         areset;
	host_ctrl_t   host_ctrl_i;
	logic [31:0]  host_data_i;
	logic         data_wr_i;
	logic         data_rd_i;
	logic         io_wr_i;
	logic [31:0]  host_rdata_o;
	disk_status_t host_status_o;
	sd_req_t      sd_req_o;
	logic [7:0]   sd_ack_i;
	logic [8:0]   sd_buff_addr_i;
	logic [7:0]   sd_buff_dout_i;
	logic         sd_buff_wr_i;
	logic [7:0]   sd_buff_din_o;
	logic [7:0]   img_mounted_i;
	logic         img_readonly_i;
	logic [31:0]  img_size_i;
	logic [1:0]   img_type_i;
	mouse_pkt_t   mouse_i;
	logic [13:0]  joy0_i;
	logic [13:0]  joy1_i;
	analog_t      joya0_i;
	analog_t      joya1_i;
	logic         y_invert_i;
	logic         swap_i;
	logic         cpu_halt_i;
	joy_route_t   joy1_o;
	joy_route_t   joy2_o;

	row_t         rows [$];
	logic [31:0]  lfsr_state = 32'h3ec1241f;
	logic         table_ready = 1'b0;
	int           model_x;
	int           model_y;
	logic         model_yinv;
	logic         model_mounted;

	disk_input_top u_disk_input_top (.*);

	always #2 clk_sys = ~clk_sys;

	// ============================================================
	// Stimulus helpers and reference model
	// ============================================================

	// Taps 32, 22, 2, 1
	function automatic logic [31:0] lfsr_take(input int nbits);
		logic [31:0] bits_out;
		logic        fb;
		bits_out = '0;
		for (int i = 0; i < nbits; i++) begin
			fb         = lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0];
			lfsr_state = {lfsr_state[30:0], fb};
			bits_out   = {bits_out[30:0], fb};
		end
		return bits_out;
	endfunction

	function automatic int limit_delta(input int d);
		if (d > `DI_MOUSE_STEP) begin
			return `DI_MOUSE_STEP;
		end
		if (d < -`DI_MOUSE_STEP) begin
			return -`DI_MOUSE_STEP;
		end
		return d;
	endfunction

	function automatic int saturate(input int v);
		if (v > `DI_AXIS_MAX) begin
			return `DI_AXIS_MAX;
		end
		if (v < `DI_AXIS_MIN) begin
			return `DI_AXIS_MIN;
		end
		return v;
	endfunction

	function automatic logic [31:0] axes_word();
		return {16'd0, 8'(model_y), 8'(model_x)};
	endfunction

	function automatic void add_row(input op_e op, input logic chk, input logic [31:0] arg,
	                                input logic [31:0] aux, input logic [31:0] want);
		rows.push_back('{op: op, chk: chk, arg: arg, aux: aux, want: want});
	endfunction

	// Mouse packet row, expected value from the running position model
	function automatic void add_packet(input int dx, input int dy, input logic [1:0] btn,
	                                   input logic show_btn);
		logic [31:0] arg;
		model_x = saturate(model_x + limit_delta(dx));
		if (model_yinv) begin
			model_y = saturate(model_y - limit_delta(dy));
		end else begin
			model_y = saturate(model_y + limit_delta(dy));
		end
		arg = {10'd0, btn, 2'd0, 9'(dy), 9'(dx)};
		if (show_btn) begin
			add_row(OP_MOUSE, 1'b1, arg, 32'd1,
			        {18'd0, JOY0_PATTERN[13:9], btn, JOY0_PATTERN[6:0]});
		end else begin
			add_row(OP_MOUSE, 1'b1, arg, 32'd0, axes_word());
		end
	endfunction

	// Drives 4 and 5 come back write protected
	function automatic void add_mount(input int drive, input logic [1:0] ftype,
	                                  input logic ro_in);
		logic [31:0] size;
		logic        ro_want;
		size          = lfsr_take(32);
		ro_want       = ro_in | (drive == 4) | (drive == 5);
		model_mounted = ~model_mounted;
		add_row(OP_MOUNT, 1'b1, {22'd0, ftype, 3'd0, ro_in, 1'b0, 3'(drive)}, size,
		        {25'd0, ro_want, ftype, 3'(drive), model_mounted});
		add_row(OP_FSIZE, 1'b1, '0, '0, size);
	endfunction

	function automatic void build_table();
		logic [31:0] val;
		logic [7:0]  bytes [16];
		model_x       = 0;
		model_y       = 0;
		model_yinv    = 1'b0;
		model_mounted = 1'b0;
		for (int i = 0; i < 2; i++) begin
			val = lfsr_take(32);
			add_row(OP_LBA, 1'b1, val, '0, val);
		end
		// Sector fill from the controller, read back on both ports
		add_row(OP_CLR, 1'b0, '0, '0, '0);
		for (int i = 0; i < 16; i++) begin
			bytes[i] = 8'(lfsr_take(8));
			val      = lfsr_take(24);
			add_row(OP_WR, 1'b0, {val[23:0], bytes[i]}, '0, '0);
		end
		add_row(OP_CLR, 1'b0, '0, '0, '0);
		for (int i = 0; i < 16; i++) begin
			add_row(OP_RD, 1'b1, '0, '0, 32'(bytes[i]));
		end
		for (int i = 0; i < 16; i++) begin
			add_row(OP_SDRD, 1'b1, 32'(i), '0, 32'(bytes[i]));
		end
		// Want word is {io_done, rd, wr}
		// A lone acknowledge raises io_done, so the first request has to clear it
		add_row(OP_ACK, 1'b1, 32'd1, '0, {15'd0, 1'b1, 16'd0});
		add_row(OP_BLOCK, 1'b1, 32'd3, 32'd0, {15'd0, 1'b0, 8'(1 << 3), 8'd0});
		add_row(OP_ACK, 1'b1, 32'(1 << 3), '0, {15'd0, 1'b1, 16'd0});
		add_row(OP_BLOCK, 1'b1, 32'd6, 32'd1, {15'd0, 1'b0, 8'd0, 8'(1 << 6)});
		add_row(OP_ACK, 1'b1, 32'(1 << 6), '0, {15'd0, 1'b1, 16'd0});
		add_mount(5, 2'b10, 1'b0);
		add_mount(2, 2'b01, 1'b0);
		add_packet(40, 40, 2'b00, 1'b0);
		add_packet(3, 3, 2'b00, 1'b0);
		add_packet(-200, -200, 2'b00, 1'b0);
		for (int i = 0; i < 14; i++) begin
			add_packet(40, 40, 2'b00, 1'b0);
		end
		model_yinv = 1'b1;
		add_row(OP_YINV, 1'b1, 32'd1, '0, axes_word());
		for (int i = 0; i < 26; i++) begin
			add_packet(-5, 40, 2'b00, 1'b0);
		end
		// Real stick takes over and the position restarts at zero
		add_row(OP_ANALOG, 1'b1, 32'h0000_30d0, '0, 32'h0000_30d0);
		model_x = 0;
		model_y = 0;
		add_row(OP_ANALOG, 1'b1, '0, '0, '0);
		val = lfsr_take(30);
		add_row(OP_SWAP, 1'b1, 32'd1, val, val);
		add_row(OP_JOY2, 1'b1, '0, '0, {2'd0, JOY0_PATTERN, 16'd0});
		add_row(OP_SWAP, 1'b1, 32'd0, val, {2'd0, JOY0_PATTERN, 16'd0});
		add_row(OP_JOY2, 1'b1, '0, '0, val);
		add_packet(0, 0, 2'b10, 1'b1);
		// Next step starts from the cleared position
		add_packet(4, 4, 2'b10, 1'b0);
	endfunction

	// ============================================================
	// Bus actions
	// ============================================================

	task automatic next_cycle();
		@(posedge clk_sys);
		#1;
	endtask

	task automatic drive_strobe(input strobe_e which, input logic level);
		case (which)
			STB_DATA_WR: data_wr_i = level;
			STB_DATA_RD: data_rd_i = level;
			default:     io_wr_i   = level;
		endcase
	endtask

	// Held 3 cycles, released 3 cycles
	task automatic strobe(input strobe_e which);
		drive_strobe(which, 1'b1);
		repeat (3) next_cycle();
		drive_strobe(which, 1'b0);
		repeat (3) next_cycle();
	endtask

	task automatic abort_run();
		$display("*** TEST FAILED ***");
		$fatal(1, "Simulation stopped at the first failure");
	endtask

	task automatic run_row(input row_t r);
		logic [31:0] got;
		string       name;
		got  = '0;
		name = "";
		case (r.op)
			OP_LBA: begin
				host_ctrl_i.lba_sel = 1'b1;
				host_data_i         = r.arg;
				strobe(STB_DATA_WR);
				host_ctrl_i.lba_sel = 1'b0;
				got  = sd_req_o.lba;
				name = "sd_req_o.lba";
			end
			OP_CLR: strobe(STB_IO_WR);
			OP_WR: begin
				host_data_i = r.arg;
				strobe(STB_DATA_WR);
			end
			OP_RD: begin
				got  = host_rdata_o;
				name = "host_rdata_o";
				strobe(STB_DATA_RD);
			end
			OP_SDRD: begin
				sd_buff_addr_i = r.arg[8:0];
				repeat (2) next_cycle();
				got  = 32'(sd_buff_din_o);
				name = "sd_buff_din_o";
			end
			OP_BLOCK: begin
				host_ctrl_i.drv_num  = r.arg[2:0];
				host_ctrl_i.block_wr = r.aux[0];
				host_ctrl_i.block_rd = ~r.aux[0];
				repeat (3) next_cycle();
				got  = {15'd0, host_status_o.io_done, sd_req_o.rd, sd_req_o.wr};
				name = "{io_done, sd_req_o.rd, sd_req_o.wr}";
				host_ctrl_i.block_rd = 1'b0;
				host_ctrl_i.block_wr = 1'b0;
				repeat (3) next_cycle();
			end
			OP_ACK: begin
				sd_ack_i = r.arg[7:0];
				repeat (3) next_cycle();
				sd_ack_i = '0;
				repeat (3) next_cycle();
				got  = {15'd0, host_status_o.io_done, sd_req_o.rd, sd_req_o.wr};
				name = "{io_done, sd_req_o.rd, sd_req_o.wr}";
			end
			OP_MOUNT: begin
				img_type_i     = r.arg[9:8];
				img_readonly_i = r.arg[4];
				img_size_i     = r.aux;
				img_mounted_i  = 8'd1 << r.arg[2:0];
				repeat (3) next_cycle();
				img_mounted_i = '0;
				repeat (3) next_cycle();
				got  = {25'd0, host_status_o[7:1]};
				name = "host_status_o[7:1]";
			end
			OP_FSIZE: begin
				host_ctrl_i.lba_sel = 1'b1;
				next_cycle();
				got  = host_rdata_o;
				name = "host_rdata_o";
				host_ctrl_i.lba_sel = 1'b0;
				next_cycle();
			end
			OP_MOUSE: begin
				mouse_i.stb = ~mouse_i.stb;
				mouse_i.dx  = r.arg[8:0];
				mouse_i.dy  = r.arg[17:9];
				mouse_i.btn = r.arg[21:20];
				repeat (3) next_cycle();
				if (r.aux[0]) begin
					got  = {18'd0, joy1_o.buttons};
					name = "joy1_o.buttons";
				end else begin
					got  = {16'd0, joy1_o.axes};
					name = "joy1_o.axes";
				end
			end
			OP_YINV: begin
				y_invert_i = r.arg[0];
				next_cycle();
				got  = {16'd0, joy1_o.axes};
				name = "joy1_o.axes";
			end
			OP_ANALOG: begin
				joya0_i = r.arg[15:0];
				repeat (3) next_cycle();
				got  = {16'd0, joy1_o.axes};
				name = "joy1_o.axes";
			end
			OP_JOY2: begin
				next_cycle();
				got  = {2'd0, joy2_o};
				name = "joy2_o";
			end
			default: begin
				swap_i  = r.arg[0];
				joy1_i  = r.aux[29:16];
				joya1_i = r.aux[15:0];
				repeat (2) next_cycle();
				got  = {2'd0, joy1_o};
				name = "joy1_o";
			end
		endcase
		if (r.chk) begin
			assert (got === r.want) else begin
				$display("** Error at %0d ns: %s = 0x%0h, expected 0x%0h",
				         $time, name, got, r.want);
				abort_run();
			end
		end
	endtask

	// ============================================================
	// Main sequence and watchdog
	// ============================================================
	initial begin
		areset         = 1'b1;
		host_ctrl_i    = '0;
		host_data_i    = '0;
		data_wr_i      = 1'b0;
		data_rd_i      = 1'b0;
		io_wr_i        = 1'b0;
		sd_ack_i       = '0;
		sd_buff_addr_i = '0;
		sd_buff_dout_i = '0;
		sd_buff_wr_i   = 1'b0;
		img_mounted_i  = '0;
		img_readonly_i = 1'b0;
		img_size_i     = '0;
		img_type_i     = '0;
		mouse_i        = '0;
		joy0_i         = JOY0_PATTERN;
		joy1_i         = '0;
		joya0_i        = '0;
		joya1_i        = '0;
		y_invert_i     = 1'b0;
		swap_i         = 1'b0;
		cpu_halt_i     = 1'b0;
		build_table();
		table_ready = 1'b1;
		repeat (2) next_cycle();
		areset = 1'b0;
		next_cycle();
		foreach (rows[i]) begin
			run_row(rows[i]);
		end
		$display("*** TEST PASSED ***");
		$finish;
	end

	initial begin
		wait (table_ready);
		repeat (rows.size() * 20 + 100) @(posedge clk_sys);
		$display("Watchdog: the run did not finish within %0d clock cycles",
		         rows.size() * 20 + 100);
		abort_run();
	end

endmodule

`default_nettype wire
